//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
out=$(./obj_dir/tb_sim 2>&1) || true
echo "$out"
echo "$out" | grep -q "^Test passed$"

//--- sim/dmem_trace.txt
# op(r/w) addr(hex) size(0 byte,1 half,2 word) wdata(hex) expected_rdata(hex) mem_requests
# write data is right aligned; expected_rdata is the whole word, ignored for writes
r a0000010 2 00000000 5fffffef 1
w a0000010 2 12345678 00000000 1
r a0000010 2 00000000 12345678 1
r 00000040 2 00000000 ffffffbf 1
r 00000040 2 00000000 ffffffbf 0
w 00000041 0 000000aa 00000000 1
r 00000040 2 00000000 ffffaabf 0
w 00000042 1 0000beef 00000000 1
r 00000040 2 00000000 beefaabf 0
r 00000080 2 00000000 ffffff7f 1
r 00000040 2 00000000 beefaabf 1
r 00000080 2 00000000 ffffff7f 1
w 000000c4 2 cafef00d 00000000 1
r 000000c4 2 00000000 cafef00d 1
r 000000c4 2 00000000 cafef00d 0
r a0000040 2 00000000 5fffffbf 1
w a0000003 0 00000055 00000000 1
r a0000000 2 00000000 55ffffff 1
r 00000041 0 00000000 beefaabf 1
w 00000080 2 00000000 00000000 1
r 00000080 2 00000000 00000000 1
r 00000080 2 00000000 00000000 0
w 00000080 1 00001234 00000000 1
r 00000080 2 00000000 00001234 0
r 00000040 2 00000000 beefaabf 1

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model import mem_pkg::*; #(
    parameter int SEED = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req,
    input  mem_req_t    mem_pkt,
    output logic        mem_addr_ok,
    output logic        mem_data_ok,
    output logic [31:0] mem_rdata
);

    // words never written read back as their inverted address
    logic [31:0] mem [logic [29:0]];
    mem_req_t    log_q [$];

    function automatic logic [31:0] read_word(input logic [29:0] w);
        if (mem.exists(w))
            return mem[w];
        return ~{w, 2'b00};
    endfunction

    function automatic logic [31:0] apply_write(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [1:0]  size,
                                                input logic [1:0]  off);
        logic [3:0]  strb;
        logic [31:0] lanes;
        logic [31:0] res;
        strb  = byte_strobe(size, off);
        lanes = wdata << {off, 3'b000};
        res   = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = lanes[8*i +: 8];
        end
        return res;
    endfunction

    // outputs change on the falling edge and inputs are sampled just before the rising edge
    initial begin
        mem_req_t    cur;
        logic        pending;
        logic        in_reset;
        int          acc_cnt;
        int          resp_cnt;
        logic [29:0] w;
        logic [31:0] old;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        cur         = '0;
        pending     = 1'b0;
        in_reset    = 1'b1;
        acc_cnt     = 0;
        resp_cnt    = 0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            mem_data_ok = 1'b0;
            mem_addr_ok = 1'b0;
            if (!in_reset) begin
                if (pending) begin
                    if (resp_cnt == 0) begin
                        w         = cur.addr.word_view.word;
                        old       = read_word(w);
                        mem_rdata = old;
                        if (cur.wr)
                            mem[w] = apply_write(old, cur.wdata, cur.size,
                                                 cur.addr.word_view.byte_off);
                        mem_data_ok = 1'b1;
                        pending     = 1'b0;
                    end else begin
                        resp_cnt--;
                    end
                end else if (acc_cnt == 0) begin
                    mem_addr_ok = 1'b1;
                end else begin
                    acc_cnt--;
                end
            end
            #4;
            if (!rst_n) begin
                in_reset = 1'b1;
                pending  = 1'b0;
                acc_cnt  = 0;
            end else begin
                in_reset = 1'b0;
                if (mem_req && mem_addr_ok) begin
                    log_q.push_back(mem_pkt);
                    cur      = mem_pkt;
                    pending  = 1'b1;
                    resp_cnt = $urandom % 4;
                    acc_cnt  = $urandom % 4;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import mem_pkg::*; ();

    localparam int SEED     = 47715;
    localparam int MAX_WAIT = 100;

    logic        clk;
    logic        rst_n;
    logic        cpu_req;
    mem_req_t    cpu_pkt;
    logic        cpu_addr_ok;
    logic        cpu_data_ok;
    logic [31:0] cpu_rdata;
    logic        mem_req;
    mem_req_t    mem_pkt;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    logic [31:0] mem_rdata;

    // expected memory contents by word address
    logic [31:0] ref_mem [logic [29:0]];

    always #5 clk = ~clk;

    dmem_subsys_top #(
        .INDEX_BITS (4)
    ) dut_i (
        .clk         (clk),         .rst_n       (rst_n),
        .cpu_req     (cpu_req),     .cpu_pkt     (cpu_pkt),
        .cpu_addr_ok (cpu_addr_ok), .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),     .mem_pkt     (mem_pkt),
        .mem_addr_ok (mem_addr_ok), .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    tb_mem_model #(
        .SEED (SEED)
    ) mem_i (
        .clk         (clk),         .rst_n       (rst_n),
        .mem_req     (mem_req),     .mem_pkt     (mem_pkt),
        .mem_addr_ok (mem_addr_ok), .mem_data_ok (mem_data_ok),
        .mem_rdata   (mem_rdata)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t ns: %s got %08h expected %08h",
                               $time, what, got, exp));
    endtask

    function automatic logic [31:0] ref_read(input logic [29:0] w);
        if (ref_mem.exists(w))
            return ref_mem[w];
        return ~{w, 2'b00};
    endfunction

    function automatic logic [31:0] merge_write(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [1:0]  size,
                                                input logic [1:0]  off);
        logic [3:0]  strb;
        logic [31:0] lanes;
        logic [31:0] res;
        strb  = byte_strobe(size, off);
        lanes = wdata << {off, 3'b000};
        res   = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = lanes[8*i +: 8];
        end
        return res;
    endfunction

    // one CPU access sampled 1 ns before each rising edge
    task automatic run_op(input logic wr, input logic [31:0] addr, input logic [1:0] size,
                          input logic [31:0] wdata, input logic [31:0] exp_rdata,
                          input int exp_mem);
        mem_req_t    pkt;
        mem_req_t    seen;
        int          log_base;
        int          cycles;
        int          lat;
        logic        got_ok;
        logic [31:0] rdata;
        logic [31:0] pred;
        pkt.wr    = wr;
        pkt.size  = size;
        pkt.addr  = addr;
        pkt.wdata = wdata;
        log_base  = mem_i.log_q.size();
        @(negedge clk);
        cpu_req = 1'b1;
        cpu_pkt = pkt;
        cycles  = 0;
        got_ok  = 1'b0;
        while (!got_ok) begin
            #4;
            got_ok = cpu_addr_ok;
            @(negedge clk);
            cycles++;
            if (!got_ok && cycles > MAX_WAIT)
                fail_run($sformatf("timeout: request to %08h never accepted", addr));
        end
        cpu_req = 1'b0;
        cpu_pkt = '0;
        lat     = 0;
        got_ok  = 1'b0;
        while (!got_ok) begin
            lat++;
            #4;
            got_ok = cpu_data_ok;
            rdata  = cpu_rdata;
            if (!got_ok) begin
                @(negedge clk);
                if (lat > MAX_WAIT)
                    fail_run($sformatf("timeout: no response for access to %08h", addr));
            end
        end

        pred = ref_read(addr[31:2]);
        if (wr) begin
            ref_mem[addr[31:2]] = merge_write(pred, wdata, size, addr[1:0]);
        end else begin
            check("read data vs trace", rdata, exp_rdata);
            check("read data vs reference", rdata, pred);
        end
        check("memory request count", 32'(mem_i.log_q.size() - log_base), 32'(exp_mem));
        if (exp_mem == 0 && !wr)
            check("hit latency", 32'(lat), 32'd1);
        if (exp_mem == 1) begin
            seen = mem_i.log_q[log_base];
            if (wr || addr[31:29] == SEG_UNCACHED) begin
                // passed through as issued
                check("mem wr", {31'b0, seen.wr}, {31'b0, wr});
                check("mem size", 32'(seen.size), 32'(size));
                check("mem addr", seen.addr, addr);
                check("mem wdata", seen.wdata, wdata);
            end else begin
                check("refill wr", {31'b0, seen.wr}, 32'd0);
                check("refill size", 32'(seen.size), 32'(SIZE_WORD));
                check("refill addr", seen.addr, {addr[31:2], 2'b00});
            end
        end
    endtask

    initial begin
        int          fd;
        int          n;
        int          n_ops;
        int          size_i;
        int          exp_mem;
        string       line;
        logic [7:0]  op_c;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        clk     = 1'b0;
        rst_n   = 1'b0;
        cpu_req = 1'b0;
        cpu_pkt = '0;
        n_ops   = 0;

        // five rising edges with rst_n low, outputs checked after each of the first four
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            #4;
            check("cpu_addr_ok in reset", {31'b0, cpu_addr_ok}, 32'd0);
            check("cpu_data_ok in reset", {31'b0, cpu_data_ok}, 32'd0);
            check("mem_req in reset", {31'b0, mem_req}, 32'd0);
        end
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("sim/dmem_trace.txt", "r");
        if (fd == 0)
            fail_run("cannot open trace file sim/dmem_trace.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%c %h %d %h %h %d", op_c, addr, size_i, wdata, exp, exp_mem);
            if (n != 6)
                fail_run({"unreadable trace line: ", line});
            run_op(op_c == "w", addr, size_i[1:0], wdata, exp, exp_mem);
            n_ops++;
        end
        $fclose(fd);
        if (n_ops == 0)
            fail_run("trace file held no operations");

        foreach (ref_mem[k]) begin
            if (!mem_i.mem.exists(k))
                fail_run($sformatf("memory model never wrote word %08h", {k, 2'b00}));
            check("final memory word", mem_i.mem[k], ref_mem[k]);
        end
        check("final written word count", 32'(mem_i.mem.num()), 32'(ref_mem.num()));

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import mem_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cached_req,
    input  mem_req_t    cached_pkt,
    output logic        cached_addr_ok,
    output logic        cached_data_ok,
    output logic [31:0] cached_rdata,

    output logic        fill_req,
    output mem_req_t    fill_pkt,
    input  logic        fill_addr_ok,
    input  logic        fill_data_ok,
    input  logic [31:0] fill_rdata
);

    localparam logic [2:0] S_IDLE       = 3'd0;
    localparam logic [2:0] S_LOOKUP     = 3'd1;
    localparam logic [2:0] S_REFILL_REQ = 3'd2;
    localparam logic [2:0] S_REFILL_WT  = 3'd3;
    localparam logic [2:0] S_WRITE_REQ  = 3'd4;
    localparam logic [2:0] S_WRITE_WT   = 3'd5;
    localparam logic [2:0] S_RESPOND    = 3'd6;

    logic [2:0]  state;
    mem_req_t    req_q;
    mem_req_t    refill_pkt;
    logic        hit;
    logic [31:0] line_rdata;
    logic        wr_en;
    logic        fill_en;
    logic [3:0]  wr_strb;
    logic [31:0] wr_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:       if (cached_req) state <= S_LOOKUP;
                S_LOOKUP: begin
                    if (req_q.wr)
                        state <= S_WRITE_REQ;
                    else if (hit)
                        state <= S_IDLE;
                    else
                        state <= S_REFILL_REQ;
                end
                S_REFILL_REQ: if (fill_addr_ok) state <= S_REFILL_WT;
                S_REFILL_WT:  if (fill_data_ok) state <= S_RESPOND;
                S_WRITE_REQ:  if (fill_addr_ok) state <= S_WRITE_WT;
                S_WRITE_WT:   if (fill_data_ok) state <= S_RESPOND;
                default:      state <= S_IDLE;
            endcase
        end
    end

    // request held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == S_IDLE && cached_req)
            req_q <= cached_pkt;
    end

    assign cached_addr_ok = (state == S_IDLE);
    // read hits answer straight out of lookup
    assign cached_data_ok = (state == S_LOOKUP && !req_q.wr && hit) || (state == S_RESPOND);
    assign cached_rdata   = line_rdata;

    // refill is always a whole aligned word
    always_comb begin
        refill_pkt                          = '0;
        refill_pkt.size                     = SIZE_WORD;
        refill_pkt.addr.word_view.word      = req_q.addr.word_view.word;
        refill_pkt.addr.word_view.byte_off  = 2'b00;
    end

    assign fill_req = (state == S_REFILL_REQ) || (state == S_WRITE_REQ);
    assign fill_pkt = (state == S_REFILL_REQ) ? refill_pkt : req_q;

    // store merges only when the tag matches
    assign wr_en   = (state == S_LOOKUP) && req_q.wr;
    assign fill_en = (state == S_REFILL_WT) && fill_data_ok;
    assign wr_strb = byte_strobe(req_q.size, req_q.addr.word_view.byte_off);
    assign wr_data = fill_en ? fill_rdata : req_q.wdata;

    dcache_store #(
        .INDEX_BITS (INDEX_BITS)
    ) store_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (req_q.addr),
        .hit         (hit),
        .line_rdata  (line_rdata),
        .wr_en       (wr_en),
        .wr_strb     (wr_strb),
        .wr_data     (wr_data),
        .fill_en     (fill_en)
    );

    // no fill traffic in idle, the merger answers only a waiting refill or write
    a_fill_resp_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        fill_data_ok |-> (state == S_REFILL_WT || state == S_WRITE_WT)
    );

    // splitter holds new cached requests until the controller is idle again
    a_req_only_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        cached_req |-> (state == S_IDLE)
    );

endmodule

`default_nettype wire

//--- source/dcache_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_store import mem_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  addr_u       lookup_addr,
    output logic        hit,
    output logic [31:0] line_rdata,
    input  logic        wr_en,
    input  logic [3:0]  wr_strb,
    input  logic [31:0] wr_data,
    input  logic        fill_en
);

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = 30 - INDEX_BITS;

    logic [LINES-1:0]    valid;
    logic [TAG_BITS-1:0] tag_mem  [LINES];
    logic [31:0]         data_mem [LINES];

    logic [INDEX_BITS-1:0] idx;
    logic [TAG_BITS-1:0]   tag;
    logic [31:0]           lane_data;

    assign idx = lookup_addr.word_view.word[INDEX_BITS-1:0];
    assign tag = lookup_addr.word_view.word[29:INDEX_BITS];

    assign hit        = valid[idx] && (tag_mem[idx] == tag);
    assign line_rdata = data_mem[idx];

    // move right-aligned cpu write data onto its lanes
    assign lane_data = wr_data << {lookup_addr.word_view.byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid <= '0;
        else if (fill_en)
            valid[idx] <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= wr_data;
        end else if (wr_en && hit) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i])
                    data_mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/dmem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_subsys_top import mem_pkg::*; #(
    parameter int INDEX_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cpu_req,
    input  mem_req_t    cpu_pkt,
    output logic        cpu_addr_ok,
    output logic        cpu_data_ok,
    output logic [31:0] cpu_rdata,

    output logic        mem_req,
    output mem_req_t    mem_pkt,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  logic [31:0] mem_rdata
);

    // cached path
    logic        cached_req;
    mem_req_t    cached_pkt;
    logic        cached_addr_ok;
    logic        cached_data_ok;
    logic [31:0] cached_rdata;

    // uncached path
    logic        unc_req;
    mem_req_t    unc_pkt;
    logic        unc_addr_ok;
    logic        unc_data_ok;
    logic [31:0] unc_rdata;

    // refill and write-through traffic
    logic        fill_req;
    mem_req_t    fill_pkt;
    logic        fill_addr_ok;
    logic        fill_data_ok;
    logic [31:0] fill_rdata;

    seg_splitter splitter_i (
        .clk            (clk),            .rst_n          (rst_n),
        .cpu_req        (cpu_req),        .cpu_pkt        (cpu_pkt),
        .cpu_addr_ok    (cpu_addr_ok),    .cpu_data_ok    (cpu_data_ok),
        .cpu_rdata      (cpu_rdata),
        .cached_req     (cached_req),     .cached_pkt     (cached_pkt),
        .cached_addr_ok (cached_addr_ok), .cached_data_ok (cached_data_ok),
        .cached_rdata   (cached_rdata),
        .unc_req        (unc_req),        .unc_pkt        (unc_pkt),
        .unc_addr_ok    (unc_addr_ok),    .unc_data_ok    (unc_data_ok),
        .unc_rdata      (unc_rdata)
    );

    dcache_ctrl #(
        .INDEX_BITS (INDEX_BITS)
    ) dcache_i (
        .clk            (clk),            .rst_n          (rst_n),
        .cached_req     (cached_req),     .cached_pkt     (cached_pkt),
        .cached_addr_ok (cached_addr_ok), .cached_data_ok (cached_data_ok),
        .cached_rdata   (cached_rdata),
        .fill_req       (fill_req),       .fill_pkt       (fill_pkt),
        .fill_addr_ok   (fill_addr_ok),   .fill_data_ok   (fill_data_ok),
        .fill_rdata     (fill_rdata)
    );

    mem_port_merger merger_i (
        .clk            (clk),            .rst_n          (rst_n),
        .fill_req       (fill_req),       .fill_pkt       (fill_pkt),
        .fill_addr_ok   (fill_addr_ok),   .fill_data_ok   (fill_data_ok),
        .fill_rdata     (fill_rdata),
        .unc_req        (unc_req),        .unc_pkt        (unc_pkt),
        .unc_addr_ok    (unc_addr_ok),    .unc_data_ok    (unc_data_ok),
        .unc_rdata      (unc_rdata),
        .mem_req        (mem_req),        .mem_pkt        (mem_pkt),
        .mem_addr_ok    (mem_addr_ok),    .mem_data_ok    (mem_data_ok),
        .mem_rdata      (mem_rdata)
    );

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // kseg1-style window that is never cached
    localparam logic [2:0] SEG_UNCACHED = 3'b101;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] rest;
    } seg_view_t;

    typedef struct packed {
        logic [29:0] word;
        logic [1:0]  byte_off;
    } word_view_t;

    // splitter decodes the segment and the cache decodes the word
    typedef union packed {
        seg_view_t  seg_view;
        word_view_t word_view;
    } addr_u;

    typedef struct packed {
        logic        wr;
        logic [1:0]  size;
        addr_u       addr;
        logic [31:0] wdata;
    } mem_req_t;

    // lane mask for a right-aligned access of the given size
    function automatic logic [3:0] byte_strobe(input logic [1:0] size,
                                               input logic [1:0] byte_off);
        logic [3:0] strb;
        case (size)
            SIZE_BYTE: strb = 4'b0001 << byte_off;
            SIZE_HALF: strb = byte_off[1] ? 4'b1100 : 4'b0011;
            default:   strb = 4'b1111;
        endcase
        return strb;
    endfunction

endpackage

`default_nettype wire

//--- source/mem_port_merger.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_merger import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        fill_req,
    input  mem_req_t    fill_pkt,
    output logic        fill_addr_ok,
    output logic        fill_data_ok,
    output logic [31:0] fill_rdata,

    input  logic        unc_req,
    input  mem_req_t    unc_pkt,
    output logic        unc_addr_ok,
    output logic        unc_data_ok,
    output logic [31:0] unc_rdata,

    output logic        mem_req,
    output mem_req_t    mem_pkt,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  logic [31:0] mem_rdata
);

    logic busy;
    logic owner_unc;
    logic grant_fill;
    logic grant_unc;

    // fill path has priority
    assign grant_fill = !busy && fill_req;
    assign grant_unc  = !busy && !fill_req && unc_req;

    assign mem_req = grant_fill || grant_unc;
    assign mem_pkt = fill_req ? fill_pkt : unc_pkt;

    assign fill_addr_ok = grant_fill && mem_addr_ok;
    assign unc_addr_ok  = grant_unc && mem_addr_ok;

    assign fill_data_ok = busy && !owner_unc && mem_data_ok;
    assign unc_data_ok  = busy && owner_unc && mem_data_ok;
    assign fill_rdata   = mem_rdata;
    assign unc_rdata    = mem_rdata;

    // one request outstanding on the memory side
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            owner_unc <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            busy      <= 1'b1;
            owner_unc <= grant_unc;
        end else if (mem_data_ok) begin
            busy <= 1'b0;
        end
    end

    a_mem_resp_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> busy
    );

endmodule

`default_nettype wire

//--- source/seg_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module seg_splitter import mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cpu_req,
    input  mem_req_t    cpu_pkt,
    output logic        cpu_addr_ok,
    output logic        cpu_data_ok,
    output logic [31:0] cpu_rdata,

    output logic        cached_req,
    output mem_req_t    cached_pkt,
    input  logic        cached_addr_ok,
    input  logic        cached_data_ok,
    input  logic [31:0] cached_rdata,

    output logic        unc_req,
    output mem_req_t    unc_pkt,
    input  logic        unc_addr_ok,
    input  logic        unc_data_ok,
    input  logic [31:0] unc_rdata
);

    logic is_unc;
    logic busy;
    // 1 when the uncached path owns the outstanding request
    logic owner_unc;

    assign is_unc = (cpu_pkt.addr.seg_view.seg == SEG_UNCACHED);

    assign cached_req = cpu_req && !busy && !is_unc;
    assign unc_req    = cpu_req && !busy && is_unc;
    assign cached_pkt = cpu_pkt;
    assign unc_pkt    = cpu_pkt;

    assign cpu_addr_ok = cpu_req && !busy && (is_unc ? unc_addr_ok : cached_addr_ok);
    assign cpu_data_ok = busy && (owner_unc ? unc_data_ok : cached_data_ok);
    assign cpu_rdata   = owner_unc ? unc_rdata : cached_rdata;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            owner_unc <= 1'b0;
        end else if (cpu_addr_ok) begin
            busy      <= 1'b1;
            owner_unc <= is_unc;
        end else if (cpu_data_ok) begin
            busy <= 1'b0;
        end
    end

    // a path may only answer while something is outstanding
    a_no_stray_data_ok: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cached_data_ok || unc_data_ok) |-> busy
    );

endmodule

`default_nettype wire

//--- tb.f
source/mem_pkg.sv
source/dcache_store.sv
source/dcache_ctrl.sv
source/seg_splitter.sv
source/mem_port_merger.sv
source/dmem_subsys_top.sv
sim/tb_mem_model.sv
sim/tb_top.sv
